// File: allocator/heapAllocator.sv
/*
  Array allocator. Freed arrays are reused last in, first out before fresh
  ones. Outputs are combinational on the current request; state moves on commit.
  Double-free protection relies on the caller gating commit with arrayLive.
*/
`timescale 1ns/100ps
`default_nettype none

`include "heap_macros.svh"

module heapAllocator (
  input  wire                        clock,
  input  wire                        reset,
  input  wire  heapPkg::heapAction_t action,
  input  wire  heapPkg::arrayId_t    array,
  input  wire                        commit,
  output logic                       arrayLive,
  output logic                       allocFault,
  output heapPkg::arrayId_t          allocResult
);
  import heapPkg::*;

  typedef logic [`HEAP_ARRAY_BITS:0] arrayCount_t;     // 0 to array count inclusive

  logic [`HEAP_ARRAYS-1:0] allocated;                  // One flag per array
  arrayId_t                freeStack [`HEAP_ARRAYS];   // Freed array numbers
  arrayCount_t             stackDepth;
  arrayCount_t             freshCount;                 // Next never-used array
  arrayId_t                topSlot;
  arrayId_t                pushSlot;
  logic                    stackEmpty;

  // ----------------------------------------
  // Request lookup
  // ----------------------------------------
  assign stackEmpty = (stackDepth == '0);
  assign topSlot    = arrayId_t'(stackDepth - 1'b1);
  assign pushSlot   = arrayId_t'(stackDepth);

  assign arrayLive  = allocated[array];

  // Top bit of freshCount set once every array has been handed out
  assign allocFault = stackEmpty && freshCount[`HEAP_ARRAY_BITS];

  assign allocResult = stackEmpty ? arrayId_t'(freshCount) : freeStack[topSlot];

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated  <= '0;
      stackDepth <= '0;
      freshCount <= '0;
    end else if (commit) begin
      case (action)
        actionClear: begin
          allocated  <= '0;
          stackDepth <= '0;
          freshCount <= '0;                            // Array 0 is fresh again
        end
        actionAlloc: begin
          allocated[allocResult] <= 1'b1;
          if (stackEmpty) begin
            freshCount <= freshCount + 1'b1;
          end else begin
            stackDepth <= stackDepth - 1'b1;           // Reuse newest freed array
          end
        end
        actionFree: begin
          allocated[array] <= 1'b0;                    // Flag of the freed array itself
          stackDepth       <= stackDepth + 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Stack contents only matter below stackDepth
  always_ff @(posedge clock) begin
    if (commit && action == actionFree) begin
      freeStack[pushSlot] <= array;
    end
  end

endmodule

`default_nettype wire

// File: common/heapPkg.sv
/*
  Types for the array heap. Every width comes from heap_macros.svh.
  Action and error encodings are fixed by enum order.
*/
`default_nettype none

`include "heap_macros.svh"

package heapPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayId_t;      // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] elemIndex_t;    // Element index
  typedef logic [`HEAP_INDEX_BITS:0]   arraySize_t;    // 0 to capacity inclusive
  typedef logic [`HEAP_DATA_BITS-1:0]  heapData_t;     // Element or result word

  // ----------------------------------------
  // Request actions
  // ----------------------------------------
  typedef enum logic [4:0] {
    actionClear,                                       // Reset allocator and sizes
    actionAlloc,
    actionFree,
    actionWrite,
    actionRead,
    actionSize,
    actionPush,
    actionPop,
    actionResize,
    actionAdd,                                         // In-place ops from here
    actionSubtract,
    actionShiftLeft,
    actionShiftRight,
    actionBitNot,
    actionBitOr,
    actionBitXor,
    actionBitAnd
  } heapAction_t;

  // ----------------------------------------
  // Response errors
  // ----------------------------------------
  typedef enum logic [2:0] {
    errorNone,
    errorNotAllocated,                                 // Array not live
    errorOutOfBounds,                                  // Index at or past size
    errorArrayFull,
    errorArrayEmpty,
    errorOutOfArrays,                                  // No free or fresh array
    errorTooLarge                                      // Resize above capacity
  } heapError_t;

endpackage

`default_nettype wire

// File: common/heap_macros.svh
/*
  Heap geometry shared by RTL and testbench. Array count and capacity are
  powers of two derived from the bit widths. Capacity must stay below 2**DATA_BITS.
*/
`ifndef HEAP_MACROS_SVH
`define HEAP_MACROS_SVH

// ----------------------------------------
// Base widths
// ----------------------------------------
`define HEAP_ARRAY_BITS 2                    // Four arrays
`define HEAP_INDEX_BITS 3                    // Eight elements per array
`define HEAP_DATA_BITS  12                   // Element and result word

// ----------------------------------------
// Derived counts
// ----------------------------------------
`define HEAP_ARRAYS   (1 << `HEAP_ARRAY_BITS)
`define HEAP_CAPACITY (1 << `HEAP_INDEX_BITS)

`endif

// File: run.sh
#!/bin/bash
# Builds the heap testbench with Verilator, runs it and checks the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module heapTb -f tb.f -o heapSim

./obj_dir/heapSim 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi

echo "Simulation PASSED"

// File: source/heapControl.sv
/*
  Request arbitration and response register. A request commits only when it
  is error free. Error priority is notAllocated, outOfArrays, then store fault.
*/
`timescale 1ns/100ps
`default_nettype none

module heapControl (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        requestValid,
  input  wire  heapPkg::heapAction_t action,
  input  wire                        arrayLive,
  input  wire                        allocFault,
  input  wire  heapPkg::arrayId_t    allocResult,
  input  wire  heapPkg::heapError_t  storeFault,
  input  wire  heapPkg::heapData_t   storeResult,
  output logic                       commit,
  output logic                       responseValid,
  output heapPkg::heapData_t         result,
  output heapPkg::heapError_t        error
);
  import heapPkg::*;

  logic       needsLive;
  heapError_t requestError;
  heapData_t  requestResult;

  // ----------------------------------------
  // Legality and priority
  // ----------------------------------------
  assign needsLive = (action != actionClear) && (action != actionAlloc);

  always_comb begin
    if (needsLive && !arrayLive) begin
      requestError = errorNotAllocated;
    end else if (action == actionAlloc && allocFault) begin
      requestError = errorOutOfArrays;
    end else begin
      requestError = storeFault;
    end
  end

  always_comb begin
    if (requestError != errorNone) begin
      requestResult = '0;                              // Failed requests return zero
    end else if (action == actionAlloc) begin
      requestResult = heapData_t'(allocResult);
    end else begin
      requestResult = storeResult;
    end
  end

  assign commit = requestValid && (requestError == errorNone);

  // ----------------------------------------
  // Response register
  // ----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      responseValid <= 1'b0;
      result        <= '0;
      error         <= errorNone;
    end else begin
      responseValid <= requestValid;                   // One cycle after each strobe
      if (requestValid) begin
        result <= requestResult;                       // Held until next response
        error  <= requestError;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/heapTop.sv
/*
  Array heap top level. One request per requestValid strobe, no back-pressure.
  Response follows one clock later; on error result is zero and no state changes.
*/
`timescale 1ns/100ps
`default_nettype none

module heapTop (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        requestValid,
  input  wire  heapPkg::heapAction_t action,
  input  wire  heapPkg::arrayId_t    array,
  input  wire  heapPkg::elemIndex_t  index,
  input  wire  heapPkg::heapData_t   data,
  output logic                       responseValid,
  output heapPkg::heapData_t         result,
  output heapPkg::heapError_t        error
);
  import heapPkg::*;

  logic       arrayLive;
  logic       allocFault;
  arrayId_t   allocResult;
  heapError_t storeFault;
  heapData_t  storeResult;
  logic       commit;                                  // Request is legal this cycle

  heapAllocator allocator (
    .clock       (clock),
    .reset       (reset),
    .action      (action),
    .array       (array),
    .commit      (commit),
    .arrayLive   (arrayLive),
    .allocFault  (allocFault),
    .allocResult (allocResult)
  );

  heapArrayStore store (
    .clock       (clock),
    .reset       (reset),
    .action      (action),
    .array       (array),
    .index       (index),
    .data        (data),
    .commit      (commit),
    .allocResult (allocResult),                        // Size zeroed on alloc
    .storeFault  (storeFault),
    .storeResult (storeResult)
  );

  heapControl control (
    .clock         (clock),
    .reset         (reset),
    .requestValid  (requestValid),
    .action        (action),
    .arrayLive     (arrayLive),
    .allocFault    (allocFault),
    .allocResult   (allocResult),
    .storeFault    (storeFault),
    .storeResult   (storeResult),
    .commit        (commit),
    .responseValid (responseValid),
    .result        (result),
    .error         (error)
  );

endmodule

`default_nettype wire

// File: store/heapArrayStore.sv
/*
  Element memory and size table for all arrays. Faults and results are
  combinational; writes happen only on commit. Liveness is checked elsewhere,
  so faults here assume the array is allocated.
*/
`timescale 1ns/100ps
`default_nettype none

`include "heap_macros.svh"

module heapArrayStore (
  input  wire                        clock,
  input  wire                        reset,
  input  wire  heapPkg::heapAction_t action,
  input  wire  heapPkg::arrayId_t    array,
  input  wire  heapPkg::elemIndex_t  index,
  input  wire  heapPkg::heapData_t   data,
  input  wire                        commit,
  input  wire  heapPkg::arrayId_t    allocResult,
  output heapPkg::heapError_t        storeFault,
  output heapPkg::heapData_t         storeResult
);
  import heapPkg::*;

  heapData_t  elements [`HEAP_ARRAYS][`HEAP_CAPACITY];
  arraySize_t sizes    [`HEAP_ARRAYS];

  arraySize_t size;
  elemIndex_t pushIndex;
  elemIndex_t popIndex;
  heapData_t  element;
  heapData_t  lastElement;
  heapData_t  updated;
  logic       inBounds;
  logic       isFull;
  logic       isEmpty;
  logic       tooLarge;
  logic       isElementOp;

  // ----------------------------------------
  // Lookup and bounds
  // ----------------------------------------
  assign size        = sizes[array];
  assign pushIndex   = elemIndex_t'(size);             // Only used below capacity
  assign popIndex    = elemIndex_t'(size - 1'b1);
  assign element     = elements[array][index];
  assign lastElement = elements[array][popIndex];

  assign inBounds = (arraySize_t'(index) < size);
  assign isFull   = size[`HEAP_INDEX_BITS];            // Size equals capacity
  assign isEmpty  = (size == '0);
  assign tooLarge = (data > heapData_t'(`HEAP_CAPACITY));

  assign isElementOp = action inside {actionAdd, actionSubtract, actionShiftLeft,
                                      actionShiftRight, actionBitNot, actionBitOr,
                                      actionBitXor, actionBitAnd};

  heapElementAlu alu (
    .action  (action),
    .element (element),
    .operand (data),
    .updated (updated)
  );

  always_comb begin
    storeFault  = errorNone;
    storeResult = '0;
    case (action)
      actionWrite: storeResult = data;
      actionRead: begin
        if (!inBounds) storeFault = errorOutOfBounds;
        storeResult = element;
      end
      actionSize: storeResult = heapData_t'(size);
      actionPush: begin
        if (isFull) storeFault = errorArrayFull;
        storeResult = data;
      end
      actionPop: begin
        if (isEmpty) storeFault = errorArrayEmpty;
        storeResult = lastElement;
      end
      actionResize: begin
        if (tooLarge) storeFault = errorTooLarge;
      end
      default: begin
        if (isElementOp) begin
          if (!inBounds) storeFault = errorOutOfBounds;
          storeResult = updated;                       // New value is returned
        end
      end
    endcase
  end

  // ----------------------------------------
  // Size table
  // ----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) sizes[i] <= '0;
    end else if (commit) begin
      case (action)
        actionClear: begin
          for (int i = 0; i < `HEAP_ARRAYS; i++) sizes[i] <= '0;
        end
        actionAlloc:  sizes[allocResult] <= '0;        // New array starts empty
        actionWrite: begin
          if (!inBounds) sizes[array] <= arraySize_t'(index) + 1'b1;
        end
        actionPush:   sizes[array] <= size + 1'b1;
        actionPop:    sizes[array] <= size - 1'b1;
        actionResize: sizes[array] <= arraySize_t'(data);
        default: ;
      endcase
    end
  end

  // Element writes
  always_ff @(posedge clock) begin
    if (commit) begin
      if (action == actionWrite) elements[array][index] <= data;
      if (action == actionPush) elements[array][pushIndex] <= data;
      if (isElementOp) elements[array][index] <= updated;   // Write back in place
    end
  end

endmodule

`default_nettype wire

// File: store/heapElementAlu.sv
/*
  In-place element operations. Pure combinational.
  Shift amounts use only the low bits of the operand.
*/
`timescale 1ns/100ps
`default_nettype none

`include "heap_macros.svh"

module heapElementAlu (
  input  wire  heapPkg::heapAction_t action,
  input  wire  heapPkg::heapData_t   element,
  input  wire  heapPkg::heapData_t   operand,
  output heapPkg::heapData_t         updated
);
  import heapPkg::*;

  localparam int ShiftBits = $clog2(`HEAP_DATA_BITS);

  logic [ShiftBits-1:0] shiftAmount;

  assign shiftAmount = operand[ShiftBits-1:0];         // Amounts past width give zero

  always_comb begin
    case (action)
      actionAdd:        updated = element + operand;   // Wraps at data width
      actionSubtract:   updated = element - operand;
      actionShiftLeft:  updated = element << shiftAmount;
      actionShiftRight: updated = element >> shiftAmount;
      actionBitNot:     updated = ~element;
      actionBitOr:      updated = element | operand;
      actionBitXor:     updated = element ^ operand;
      actionBitAnd:     updated = element & operand;
      default:          updated = element;             // Not an in-place action
    endcase
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/heapPkg.sv
allocator/heapAllocator.sv
store/heapElementAlu.sv
store/heapArrayStore.sv
source/heapControl.sv
source/heapTop.sv
test/heap_checker.sv
test/heapTb.sv

// File: test/heapTb.sv
/*
  Directed testbench for heapTop. A shadow model of liveness, sizes, elements
  and the free stack predicts every response. Random stimulus uses seed 24.
*/
`timescale 1ns/100ps
`default_nettype none

`include "heap_macros.svh"

module heapTb;
  import heapPkg::*;

  localparam int Arrays        = `HEAP_ARRAYS;
  localparam int Capacity      = `HEAP_CAPACITY;
  localparam int ShiftBits     = $clog2(`HEAP_DATA_BITS);
  localparam int BurstLength   = 12;
  localparam int RequestBudget = 250;                   // Above the request count of all tests
  localparam int WatchdogNs    = RequestBudget * 3 * 10 + 1000;   // Three cycles per request

  logic        clock;
  logic        reset;
  logic        requestValid;
  heapAction_t action;
  arrayId_t    array;
  elemIndex_t  index;
  heapData_t   data;
  logic        responseValid;
  heapData_t   result;
  heapError_t  error;

  int errorCount;
  int testCount;
  int failedTests;

  // Shadow model
  logic      modelLive [Arrays];
  int        modelSize [Arrays];
  heapData_t modelElem [Arrays][Capacity];
  int        freeStack [$];
  int        modelFresh;

  heapAction_t elementOps [8] = '{actionAdd, actionSubtract, actionShiftLeft, actionShiftRight,
                                  actionBitNot, actionBitOr, actionBitXor, actionBitAnd};

  heapTop dut (
    .clock         (clock),
    .reset         (reset),
    .requestValid  (requestValid),
    .action        (action),
    .array         (array),
    .index         (index),
    .data          (data),
    .responseValid (responseValid),
    .result        (result),
    .error         (error)
  );

  bind heapControl heapChecker responseCheck (
    .clock(clock), .reset(reset), .requestValid(requestValid),
    .responseValid(responseValid), .result(result), .error(error)
  );

  always #5 clock = ~clock;

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic void resetModel();
    for (int a = 0; a < Arrays; a++) begin
      modelLive[a] = 1'b0;
      modelSize[a] = 0;
    end
    freeStack.delete();
    modelFresh = 0;
  endfunction

  function automatic void predict(input heapAction_t act, input int arr, input int idx,
                                  input heapData_t dat, output heapData_t expResult,
                                  output heapError_t expError);
    heapData_t            elem;
    logic [ShiftBits-1:0] shift;
    expResult = '0;
    expError  = errorNone;
    elem      = modelElem[arr][idx];
    shift     = dat[ShiftBits-1:0];
    if (!(act inside {actionClear, actionAlloc}) && !modelLive[arr]) begin
      expError = errorNotAllocated;
      return;
    end
    case (act)
      actionClear: resetModel();
      actionAlloc: begin
        if (freeStack.size() > 0) begin
          arr = freeStack.pop_back();                   // Newest freed array first
        end else if (modelFresh < Arrays) begin
          arr = modelFresh;
          modelFresh++;
        end else begin
          expError = errorOutOfArrays;
          return;
        end
        modelLive[arr] = 1'b1;
        modelSize[arr] = 0;
        expResult      = heapData_t'(arr);
      end
      actionFree: begin
        modelLive[arr] = 1'b0;
        freeStack.push_back(arr);
      end
      actionWrite: begin
        modelElem[arr][idx] = dat;
        if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;
        expResult = dat;
      end
      actionRead: begin
        if (idx >= modelSize[arr]) expError = errorOutOfBounds;
        else expResult = elem;
      end
      actionSize: expResult = heapData_t'(modelSize[arr]);
      actionPush: begin
        if (modelSize[arr] == Capacity) begin
          expError = errorArrayFull;
        end else begin
          modelElem[arr][modelSize[arr]] = dat;
          modelSize[arr]++;
          expResult = dat;
        end
      end
      actionPop: begin
        if (modelSize[arr] == 0) begin
          expError = errorArrayEmpty;
        end else begin
          modelSize[arr]--;
          expResult = modelElem[arr][modelSize[arr]];
        end
      end
      actionResize: begin
        if (int'(dat) > Capacity) expError = errorTooLarge;
        else modelSize[arr] = int'(dat);
      end
      default: begin
        if (idx >= modelSize[arr]) begin
          expError = errorOutOfBounds;
          return;
        end
        case (act)
          actionAdd:        elem = elem + dat;
          actionSubtract:   elem = elem - dat;
          actionShiftLeft:  elem = elem << shift;
          actionShiftRight: elem = elem >> shift;
          actionBitNot:     elem = ~elem;
          actionBitOr:      elem = elem | dat;
          actionBitXor:     elem = elem ^ dat;
          actionBitAnd:     elem = elem & dat;
          default: ;
        endcase
        modelElem[arr][idx] = elem;                     // In-place write back
        expResult = elem;
      end
    endcase
  endfunction

  // ----------------------------------------
  // Compare tasks and request driver
  // ----------------------------------------
  task automatic compareData(input string name, input heapData_t actual,
                             input heapData_t expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic compareError(input string name, input heapError_t actual,
                              input heapError_t expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%h (%s), expected 0x%h (%s)", name, actual, actual.name(),
               expected, expected.name());
      errorCount++;
    end
  endtask

  task automatic compareBit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic doRequest(input heapAction_t act, input int arr, input int idx, input int dat,
                           output heapData_t got, output heapError_t gotError);
    heapData_t  expResult;
    heapError_t expError;
    int         waitCycles;
    @(posedge clock);
    #1;
    requestValid = 1'b1;
    action       = act;
    array        = arrayId_t'(arr);
    index        = elemIndex_t'(idx);
    data         = heapData_t'(dat);
    predict(act, arr, idx, heapData_t'(dat), expResult, expError);
    @(posedge clock);
    #1;
    requestValid = 1'b0;
    waitCycles   = 0;
    @(negedge clock);
    while (!responseValid && waitCycles < 8) begin
      @(negedge clock);
      waitCycles++;
    end
    got      = result;
    gotError = error;
    if (!responseValid) begin
      $display("No response to %s within 8 cycles", act.name());
      errorCount++;
    end else begin
      compareData("result", got, expResult);
      compareError("error", gotError, expError);
    end
  endtask

  task automatic reportTest(input string name, input int errorsAtStart);
    testCount++;
    if (errorCount == errorsAtStart) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errorCount - errorsAtStart);
      failedTests++;
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic checkReset();
    int         start;
    heapData_t  got;
    heapError_t err;
    start = errorCount;
    @(negedge clock);
    compareBit("responseValid", responseValid, 1'b0);
    doRequest(actionRead, 0, 0, 0, got, err);
    compareError("read error", err, errorNotAllocated);
    doRequest(actionFree, 0, 0, 0, got, err);
    compareError("free error", err, errorNotAllocated);
    reportTest("reset", start);
  endtask

  task automatic checkAllocation();
    int         start;
    heapData_t  got;
    heapError_t err;
    start = errorCount;
    doRequest(actionClear, 0, 0, 0, got, err);
    for (int i = 0; i < Arrays; i++) begin
      doRequest(actionAlloc, 0, 0, 0, got, err);
      compareData("alloc result", got, heapData_t'(i));
    end
    doRequest(actionAlloc, 0, 0, 0, got, err);
    compareError("alloc error", err, errorOutOfArrays);
    doRequest(actionFree, 1, 0, 0, got, err);
    doRequest(actionFree, 2, 0, 0, got, err);
    doRequest(actionAlloc, 0, 0, 0, got, err);
    compareData("alloc result", got, 12'd2);            // Last freed comes back first
    doRequest(actionAlloc, 0, 0, 0, got, err);
    compareData("alloc result", got, 12'd1);
    doRequest(actionFree, 3, 0, 0, got, err);
    doRequest(actionFree, 3, 0, 0, got, err);
    compareError("double free error", err, errorNotAllocated);
    doRequest(actionClear, 0, 0, 0, got, err);
    doRequest(actionAlloc, 0, 0, 0, got, err);
    compareData("alloc result", got, 12'd0);
    reportTest("allocation", start);
  endtask

  task automatic checkReadWrite();
    int         start;
    int         a;
    int         b;
    heapData_t  got;
    heapError_t err;
    start = errorCount;
    doRequest(actionClear, 0, 0, 0, got, err);
    doRequest(actionAlloc, 0, 0, 0, got, err);
    a = int'(got);
    doRequest(actionAlloc, 0, 0, 0, got, err);
    b = int'(got);
    doRequest(actionWrite, a, 0, 11, got, err);
    doRequest(actionWrite, a, 1, 22, got, err);
    doRequest(actionWrite, b, 1, 33, got, err);
    doRequest(actionRead, a, 0, 0, got, err);
    compareData("a[0]", got, 12'd11);
    doRequest(actionRead, a, 1, 0, got, err);
    compareData("a[1]", got, 12'd22);
    doRequest(actionRead, b, 1, 0, got, err);
    compareData("b[1]", got, 12'd33);
    doRequest(actionSize, b, 0, 0, got, err);
    compareData("size of b", got, 12'd2);
    doRequest(actionRead, a, 2, 0, got, err);
    compareError("read error", err, errorOutOfBounds);
    reportTest("read and write", start);
  endtask

  task automatic checkStack();
    int         start;
    heapData_t  got;
    heapError_t err;
    start = errorCount;
    doRequest(actionClear, 0, 0, 0, got, err);
    doRequest(actionAlloc, 0, 0, 0, got, err);
    for (int i = 0; i < Capacity; i++) begin
      doRequest(actionPush, 0, 0, 100 + i, got, err);
    end
    doRequest(actionPush, 0, 0, 999, got, err);
    compareError("push error", err, errorArrayFull);
    for (int i = Capacity - 1; i >= 0; i--) begin
      doRequest(actionPop, 0, 0, 0, got, err);
      compareData("pop result", got, heapData_t'(100 + i));   // Reverse order
    end
    doRequest(actionPop, 0, 0, 0, got, err);
    compareError("pop error", err, errorArrayEmpty);
    doRequest(actionResize, 0, 0, Capacity + 1, got, err);
    compareError("resize error", err, errorTooLarge);
    reportTest("push and pop", start);
  endtask

  task automatic checkElementOps();
    int         start;
    int         a;
    int         i;
    heapData_t  got;
    heapData_t  readBack;
    heapError_t err;
    heapError_t readErr;
    start = errorCount;
    doRequest(actionClear, 0, 0, 0, got, err);
    for (a = 0; a < Arrays; a++) begin
      doRequest(actionAlloc, 0, 0, 0, got, err);
      for (i = 0; i < Capacity; i++) begin
        doRequest(actionWrite, a, i, $urandom, got, err);
      end
    end
    doRequest(actionResize, Arrays - 1, 0, Capacity / 2, got, err);   // Upper half out of bounds
    repeat (40) begin
      a = $urandom % Arrays;
      i = $urandom % Capacity;
      doRequest(elementOps[$urandom % 8], a, i, $urandom, got, err);
      doRequest(actionRead, a, i, 0, readBack, readErr);
      if (i < modelSize[a]) compareData("read back", readBack, modelElem[a][i]);
    end
    reportTest("element operations", start);
  endtask

  task automatic checkBackToBack();
    int         start;
    int         pick;
    heapData_t  expData [$];
    heapError_t expErr [$];
    heapData_t  r;
    heapError_t e;
    start = errorCount;
    fork
      begin
        for (int n = 0; n < BurstLength; n++) begin
          @(posedge clock);
          #1;
          pick         = $urandom % 3;
          requestValid = 1'b1;
          action       = (pick == 0) ? actionWrite :
                         (pick == 1) ? actionRead : elementOps[$urandom % 8];
          array        = arrayId_t'($urandom % Arrays);
          index        = elemIndex_t'($urandom % Capacity);
          data         = heapData_t'($urandom);
          predict(action, int'(array), int'(index), data, r, e);
          expData.push_back(r);
          expErr.push_back(e);
        end
        @(posedge clock);
        #1;
        requestValid = 1'b0;
      end
      begin
        @(negedge clock);                               // First request not clocked yet
        for (int n = 0; n < BurstLength; n++) begin
          @(negedge clock);
          compareBit("responseValid", responseValid, 1'b1);
          compareData("result", result, expData.pop_front());
          compareError("error", error, expErr.pop_front());
        end
        @(negedge clock);
        compareBit("responseValid", responseValid, 1'b0);
      end
    join
    reportTest("back to back", start);
  endtask

  // ----------------------------------------
  // Run control
  // ----------------------------------------
  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, run stopped", WatchdogNs);
    $display("Test failures found");
    $finish;
  end

  initial begin
    clock        = 1'b0;
    reset        = 1'b0;
    requestValid = 1'b0;
    action       = actionClear;
    array        = '0;
    index        = '0;
    data         = '0;
    errorCount   = 0;
    testCount    = 0;
    failedTests  = 0;
    void'($urandom(24));
    resetModel();
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b1;
    checkReset();
    checkAllocation();
    checkReadWrite();
    checkStack();
    checkElementOps();
    checkBackToBack();
    $display("Summary: %0d tests, %0d failed, %0d check errors", testCount, failedTests,
             errorCount);
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/heap_checker.sv
/*
  Response timing assertions, bound into heapControl by the testbench.
  All checks are off while reset is low.
*/
`timescale 1ns/100ps
`default_nettype none

module heapChecker (
  input wire                      clock,
  input wire                      reset,
  input wire                      requestValid,
  input wire                      responseValid,
  input wire heapPkg::heapData_t  result,
  input wire heapPkg::heapError_t error
);
  import heapPkg::*;

  // ----------------------------------------
  // Handshake timing
  // ----------------------------------------
  responseFollowsRequest: assert property (
    @(posedge clock) disable iff (!reset) requestValid |=> responseValid
  ) else $error("responseValid missing one cycle after requestValid");

  noSpuriousResponse: assert property (
    @(posedge clock) disable iff (!reset) responseValid |-> $past(requestValid)
  ) else $error("responseValid without a request in the cycle before");

  // Failed requests carry a zero result
  zeroResultOnError: assert property (
    @(posedge clock) disable iff (!reset) (error != errorNone) |-> (result == '0)
  ) else $error("result 0x%h is not zero while an error is reported", result);

endmodule

`default_nettype wire
